// ==== tb.f ====
rtl/load_pkg.sv
rtl/load_dispatch.sv
rtl/load_unit.sv
rtl/read_arbiter.sv
rtl/load_writeback.sv
rtl/load_subsystem.sv
verification/mem_model.sv
verification/tb_load_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_load_subsystem
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_load_subsystem.sv ====
module tb_load_subsystem
    import load_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_units      = 4;
    localparam int id_width       = $clog2(num_units);
    localparam int num_loads      = 300;
    // full stall window plus longest delay plus drain slack, per load
    localparam int stall_window   = 40;
    localparam int timeout_cycles = num_loads * (stall_window + 15 + 8) + 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid, req_signed, req_full;
    logic [xlen-1:0]      req_base, req_offset;
    logic [1:0]           req_size;
    logic [tag_width-1:0] req_tag, wb_tag;
    logic                 ar_valid, ar_ready, r_valid, wb_valid;
    logic [xlen-1:0]      ar_addr, r_data, wb_data, fill_data;
    logic [id_width-1:0]  ar_id, r_id;
    logic                 stall;
    logic [3:0]           delay;

    // scoreboard by tag
    bit              pending  [32];
    logic [xlen-1:0] exp_data [32];
    int issued, wb_count, outstanding, cycles;
    int mismatch_errors, protocol_errors;
    logic [15:0] lfsr_state;
    bit rst_prev, ar_hold;
    logic [xlen-1:0]     held_addr;
    logic [id_width-1:0] held_id;

    load_subsystem #(.num_units(num_units)) DUT (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_base(req_base),
        .req_offset(req_offset), .req_size(req_size), .req_signed(req_signed),
        .req_tag(req_tag), .req_full(req_full), .ar_valid(ar_valid), .ar_addr(ar_addr),
        .ar_id(ar_id), .ar_ready(ar_ready), .r_valid(r_valid), .r_id(r_id),
        .r_data(r_data), .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data)
    );

    mem_model #(.num_units(num_units)) u_mem (
        .clk(clk), .rst_n(rst_n), .ar_valid(ar_valid), .ar_id(ar_id),
        .fill_data(fill_data), .stall(stall), .delay(delay), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_id(r_id), .r_data(r_data)
    );

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // memory contents, a hash of the aligned address
    function automatic logic [63:0] mix_dword(input logic [63:0] addr);
        logic [63:0] x;
        x = addr ^ 64'h5bd1_e995_5bd1_e995;
        x = x ^ (x >> 31);
        x = x * 64'h9e37_79b9_7f4a_7c15;
        x = x ^ (x >> 29);
        return x;
    endfunction

    // reference load result: lane by addr[2:0], then extend
    function automatic logic [63:0] expect_load(input logic [63:0] addr,
                                                input logic [1:0] size, input logic sgn);
        dword_lanes_u lanes;
        logic [63:0]  raw;
        int           nbits;
        lanes.dword = mix_dword({addr[63:3], 3'b000});
        case (size)
            size_byte: begin
                raw   = {56'd0, lanes.b[addr[2:0]]};
                nbits = 8;
            end
            size_half: begin
                raw   = {48'd0, lanes.h[addr[2:1]]};
                nbits = 16;
            end
            size_word: begin
                raw   = {32'd0, lanes.w[addr[2]]};
                nbits = 32;
            end
            default: begin
                raw   = lanes.dword;
                nbits = 64;
            end
        endcase
        if (sgn && nbits < 64 && raw[nbits-1]) raw = raw | (~64'd0 << nbits);
        return raw;
    endfunction

    // memory answers with the hash of whatever address is on the bus
    assign fill_data = mix_dword(ar_addr);

    task automatic issue_load();
        logic [1:0]  size;
        logic        sgn;
        logic [11:0] r12;
        logic [63:0] base, offset, addr;
        logic [4:0]  tag;
        size   = 2'(rand_bits(2));
        sgn    = 1'(rand_bits(1));
        base   = rand_bits(64);
        r12    = 12'(rand_bits(12));
        offset = {{52{r12[11]}}, r12};
        // pull the offset down to a naturally aligned address
        addr   = base + offset;
        offset = offset - (addr & ((64'd1 << size) - 64'd1));
        addr   = base + offset;
        tag    = 5'(rand_bits(5));
        // skip tags still in flight or retiring this edge
        while (pending[tag] || (wb_valid && wb_tag == tag)) tag = tag + 5'd1;
        pending[tag]  = 1'b1;
        exp_data[tag] = expect_load(addr, size, sgn);
        req_valid  <= 1'b1;
        req_base   <= base;
        req_offset <= offset;
        req_size   <= size;
        req_signed <= sgn;
        req_tag    <= tag;
        issued++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs quiet in reset and on the first cycle out of it
    always @(posedge clk) begin
        if (!rst_n || !rst_prev) begin
            assert (!ar_valid && !wb_valid && !req_full) else begin
                protocol_errors++;
                $display("outputs not low during or right after reset at %0t", $time);
            end
        end
        rst_prev <= rst_n;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            assert (outstanding <= num_units) else begin
                protocol_errors++;
                $display("more than %0d loads outstanding at %0t", num_units, $time);
            end
            assert (req_full == (outstanding == num_units)) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: req_full %b with %0d loads outstanding",
                         $time, req_full, outstanding);
            end
            // pending read must not move before acceptance
            if (ar_hold) begin
                assert (ar_valid && ar_addr == held_addr && ar_id == held_id) else begin
                    protocol_errors++;
                    $display("read request changed before ar_ready at %0t", $time);
                end
            end
            if (ar_valid) begin
                assert (ar_addr[2:0] == 3'd0) else begin
                    protocol_errors++;
                    $display("ar_addr %h not doubleword aligned at %0t", ar_addr, $time);
                end
            end
            ar_hold   <= ar_valid && !ar_ready;
            held_addr <= ar_addr;
            held_id   <= ar_id;
            if (wb_valid) begin
                assert (pending[wb_tag]) else begin
                    protocol_errors++;
                    $display("writeback of tag %0d that is not outstanding at %0t",
                             wb_tag, $time);
                end
                if (pending[wb_tag]) begin
                    assert (wb_data == exp_data[wb_tag]) else begin
                        mismatch_errors++;
                        $display("Mismatch at %0t: tag %0d wb_data %h expected %h",
                                 $time, wb_tag, wb_data, exp_data[wb_tag]);
                    end
                end
                pending[wb_tag] = 1'b0;
                wb_count++;
            end
            outstanding <= outstanding + int'(req_valid) - int'(wb_valid);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d loads written back",
                     cycles, wb_count, num_loads);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int  phase;
        bit  last_strobe;
        lfsr_state  = 16'd67;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_base    = '0;
        req_offset  = '0;
        req_size    = '0;
        req_signed  = 1'b0;
        req_tag     = '0;
        stall       = 1'b1;
        delay       = '0;
        phase       = 0;
        last_strobe = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (wb_count < num_loads) begin
            @(posedge clk);
            // full stall window every 200 cycles lets the units pile up
            phase = (phase == 199) ? 0 : phase + 1;
            stall <= (phase < stall_window) || (rand_bits(2) == 64'd0);
            delay <= 4'(rand_bits(4));
            req_valid <= 1'b0;
            // a gap after each strobe so req_full has caught up
            if (issued < num_loads && !req_full && !last_strobe && rand_bits(2) != 64'd0) begin
                issue_load();
                last_strobe = 1'b1;
            end else begin
                last_strobe = 1'b0;
            end
        end
        @(negedge clk);
        for (int t = 0; t < 32; t++) begin
            assert (!pending[t]) else begin
                protocol_errors++;
                $display("tag %0d was never written back", t);
            end
        end
        $display("errors: %0d mismatch, %0d protocol; %0d loads issued, %0d written back",
                 mismatch_errors, protocol_errors, issued, wb_count);
        if (mismatch_errors + protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/mem_model.sv ====
module mem_model
    import load_pkg::*;
#(
    parameter int  num_units = 4,
    localparam int id_width  = (num_units > 1) ? $clog2(num_units) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ar_valid,
    input  logic [id_width-1:0] ar_id,
    input  logic [xlen-1:0]     fill_data,
    input  logic                stall,
    input  logic [3:0]          delay,
    output logic                ar_ready,
    output logic                r_valid,
    output logic [id_width-1:0] r_id,
    output logic [xlen-1:0]     r_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // one slot per id, a unit never has two reads in flight
    logic            pend  [num_units];
    logic [3:0]      count [num_units];
    logic [xlen-1:0] data  [num_units];

    always @(posedge clk or negedge rst_n) begin
        bit sent;
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_id     <= '0;
            r_data   <= '0;
            for (int i = 0; i < num_units; i++) begin
                pend[i]  <= 1'b0;
                count[i] <= '0;
            end
        end else begin
            sent = 1'b0;
            // stall level comes from the testbench random source
            ar_ready <= !stall;
            r_valid  <= 1'b0;
            // count down, then answer the lowest expired slot
            for (int i = 0; i < num_units; i++) begin
                if (pend[i] && count[i] != 4'd0) begin
                    count[i] <= count[i] - 4'd1;
                end else if (pend[i] && !sent) begin
                    sent = 1'b1;
                    r_valid <= 1'b1;
                    r_id    <= id_width'(i);
                    r_data  <= data[i];
                    pend[i] <= 1'b0;
                end
            end
            // accepted read, slot is free since the unit waits on it
            if (ar_valid && ar_ready) begin
                pend[ar_id]  <= 1'b1;
                count[ar_id] <= delay;
                data[ar_id]  <= fill_data;
            end
        end
    end

endmodule

// ==== rtl/load_subsystem.sv ====
module load_subsystem
    import load_pkg::*;
#(
    parameter int  num_units = 4,
    localparam int id_width  = (num_units > 1) ? $clog2(num_units) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  logic [xlen-1:0]      req_base,
    input  logic [xlen-1:0]      req_offset,
    input  logic [1:0]           req_size,
    input  logic                 req_signed,
    input  logic [tag_width-1:0] req_tag,
    output logic                 req_full,
    output logic                 ar_valid,
    output logic [xlen-1:0]      ar_addr,
    output logic [id_width-1:0]  ar_id,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  logic [id_width-1:0]  r_id,
    input  logic [xlen-1:0]      r_data,
    output logic                 wb_valid,
    output logic [tag_width-1:0] wb_tag,
    output logic [xlen-1:0]      wb_data
);

    // per-unit control levels and pulses
    logic [num_units-1:0] start, busy, rd_req, grant, resp, done, drain;
    // per-unit payload, flattened with unit 0 in the low bits
    logic [num_units*xlen-1:0]      rd_addr;
    logic [num_units*tag_width-1:0] res_tag;
    logic [num_units*xlen-1:0]      res_data;

    load_dispatch #(.num_units(num_units)) u_dispatch (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .busy(busy),
        .start(start), .req_full(req_full)
    );

    // request fields and read data go to every unit
    for (genvar i = 0; i < num_units; i++) begin : g_unit
        load_unit u_load_unit (
            .clk(clk), .rst_n(rst_n), .start(start[i]),
            .req_base(req_base), .req_offset(req_offset), .req_size(req_size),
            .req_signed(req_signed), .req_tag(req_tag),
            .grant(grant[i]), .resp(resp[i]), .r_data(r_data), .drain(drain[i]),
            .busy(busy[i]), .rd_req(rd_req[i]), .rd_addr(rd_addr[i*xlen +: xlen]),
            .done(done[i]), .res_tag(res_tag[i*tag_width +: tag_width]),
            .res_data(res_data[i*xlen +: xlen])
        );
    end

    read_arbiter #(.num_units(num_units)) u_arbiter (
        .clk(clk), .rst_n(rst_n), .rd_req(rd_req), .rd_addr(rd_addr),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_id(r_id),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_id(ar_id),
        .grant(grant), .resp(resp)
    );

    load_writeback #(.num_units(num_units)) u_writeback (
        .clk(clk), .rst_n(rst_n), .done(done), .res_tag(res_tag), .res_data(res_data),
        .drain(drain), .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data)
    );

endmodule

// ==== rtl/load_writeback.sv ====
module load_writeback
    import load_pkg::*;
#(
    parameter int  num_units = 4,
    localparam int id_width  = (num_units > 1) ? $clog2(num_units) : 1
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [num_units-1:0]           done,
    input  logic [num_units*tag_width-1:0] res_tag,
    input  logic [num_units*xlen-1:0]      res_data,
    output logic [num_units-1:0]           drain,
    output logic                           wb_valid,
    output logic [tag_width-1:0]           wb_tag,
    output logic [xlen-1:0]                wb_data
);

    // next unit to look at first
    logic [id_width-1:0] ptr;
    logic                found;
    logic [id_width-1:0] sel;

    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < num_units; i++) begin
            idx = (int'(ptr) + i) % num_units;
            if (!found && done[idx]) begin
                found = 1'b1;
                sel   = id_width'(idx);
            end
        end
    end

    always_comb begin
        drain = '0;
        // at most one unit drained per cycle
        if (found) drain[sel] = 1'b1;
    end

    // pointer moves past the unit just drained
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= found;
            if (found) ptr <= (sel == id_width'(num_units - 1)) ? '0 : sel + 1'b1;
        end
    end

    // result lands on the port one cycle after the drain
    always_ff @(posedge clk) begin
        if (found) begin
            wb_tag  <= res_tag[sel*tag_width +: tag_width];
            wb_data <= res_data[sel*xlen +: xlen];
        end
    end

endmodule

// ==== rtl/read_arbiter.sv ====
module read_arbiter
    import load_pkg::*;
#(
    parameter int  num_units = 4,
    localparam int id_width  = (num_units > 1) ? $clog2(num_units) : 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [num_units-1:0]      rd_req,
    input  logic [num_units*xlen-1:0] rd_addr,
    input  logic                      ar_ready,
    input  logic                      r_valid,
    input  logic [id_width-1:0]       r_id,
    output logic                      ar_valid,
    output logic [xlen-1:0]           ar_addr,
    output logic [id_width-1:0]       ar_id,
    output logic [num_units-1:0]      grant,
    output logic [num_units-1:0]      resp
);

    // round-robin start point, one past the last granted unit
    logic [id_width-1:0] ptr;
    // request on the bus but not yet accepted
    logic                locked;
    logic [id_width-1:0] lock_id;

    // result of the round-robin search
    logic                rr_found;
    logic [id_width-1:0] rr_id;
    logic [id_width-1:0] sel;
    logic                accept;

    always_comb begin
        int idx;
        rr_found = 1'b0;
        rr_id    = '0;
        // first requester at or after the pointer
        for (int i = 0; i < num_units; i++) begin
            idx = (int'(ptr) + i) % num_units;
            if (!rr_found && rd_req[idx]) begin
                rr_found = 1'b1;
                rr_id    = id_width'(idx);
            end
        end
    end

    // a pending request keeps its slot until accepted
    assign sel      = locked ? lock_id : rr_id;
    assign ar_valid = locked | rr_found;
    assign ar_id    = sel;
    assign ar_addr  = rd_addr[sel*xlen +: xlen];
    assign accept   = ar_valid & ar_ready;

    always_comb begin
        grant = '0;
        // acceptance goes back only to the owner of ar_id
        if (accept) grant[sel] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr     <= '0;
            locked  <= 1'b0;
            lock_id <= '0;
        end else if (accept) begin
            locked <= 1'b0;
            ptr    <= (sel == id_width'(num_units - 1)) ? '0 : sel + 1'b1;
        end else if (ar_valid) begin
            locked  <= 1'b1;
            lock_id <= sel;
        end
    end

    // response pulse to the unit named by r_id
    always_comb begin
        for (int i = 0; i < num_units; i++) begin
            resp[i] = r_valid && (r_id == id_width'(i));
        end
    end

endmodule

// ==== rtl/load_unit.sv ====
module load_unit
    import load_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [xlen-1:0]      req_base,
    input  logic [xlen-1:0]      req_offset,
    input  logic [1:0]           req_size,
    input  logic                 req_signed,
    input  logic [tag_width-1:0] req_tag,
    input  logic                 grant,
    input  logic                 resp,
    input  logic [xlen-1:0]      r_data,
    input  logic                 drain,
    output logic                 busy,
    output logic                 rd_req,
    output logic [xlen-1:0]      rd_addr,
    output logic                 done,
    output logic [tag_width-1:0] res_tag,
    output logic [xlen-1:0]      res_data
);

    // fsm encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req  = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;

    // effective address, base plus offset
    logic [xlen-1:0] eff_addr;

    // captured request
    logic [xlen-1:0]      addr_q;
    logic [lane_bits-1:0] lane_q;
    logic [1:0]           size_q;
    logic                 signed_q;
    logic [tag_width-1:0] tag_q;
    logic [xlen-1:0]      data_q;

    // read beat split into lanes
    dword_lanes_u    lanes;
    logic [xlen-1:0] ext_data;

    assign eff_addr = req_base + req_offset;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: if (start) state_next = st_req;
            // hold the request until the arbiter accepts it
            st_req:  if (grant) state_next = st_wait;
            // response may come back after any number of cycles
            st_wait: if (resp) state_next = st_done;
            // result held until the collector takes it
            st_done: if (drain) state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // request fields only load when idle, so the bus address stays put
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            addr_q   <= {eff_addr[xlen-1:lane_bits], {lane_bits{1'b0}}};
            lane_q   <= eff_addr[lane_bits-1:0];
            size_q   <= req_size;
            signed_q <= req_signed;
            tag_q    <= req_tag;
        end
    end

    assign lanes = r_data;

    // pick the lane, then sign or zero extend
    always_comb begin
        case (size_q)
            size_byte: begin
                ext_data = {{(xlen-8){signed_q & lanes.b[lane_q][7]}}, lanes.b[lane_q]};
            end
            size_half: begin
                ext_data = {{(xlen-16){signed_q & lanes.h[lane_q[2:1]][15]}},
                            lanes.h[lane_q[2:1]]};
            end
            size_word: begin
                ext_data = {{(xlen-32){signed_q & lanes.w[lane_q[2]][31]}},
                            lanes.w[lane_q[2]]};
            end
            // full doubleword, nothing to extend
            default: ext_data = lanes.dword;
        endcase
    end

    // capture extended result on the response pulse
    always_ff @(posedge clk) begin
        if (state == st_wait && resp) begin
            data_q <= ext_data;
        end
    end

    assign busy     = (state != st_idle);
    assign rd_req   = (state == st_req);
    assign done     = (state == st_done);
    assign rd_addr  = addr_q;
    assign res_tag  = tag_q;
    assign res_data = data_q;

endmodule

// ==== rtl/load_dispatch.sv ====
module load_dispatch #(
    parameter int num_units = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  logic [num_units-1:0] busy,
    output logic [num_units-1:0] start,
    output logic                 req_full
);

    // units that can take a new load this cycle
    logic [num_units-1:0] free;
    // lowest free unit as a one-hot vector
    logic [num_units-1:0] lowest_free;
    // units that will be busy after this edge
    logic [num_units-1:0] busy_next;

    assign free = ~busy;

    // two's complement trick isolates the lowest set bit
    assign lowest_free = free & (~free + 1'b1);

    // start pulse in the same cycle as the strobe
    // requester never strobes while full, so a free unit exists
    assign start = req_valid ? lowest_free : '0;

    // a unit started now is busy from the next edge on
    assign busy_next = busy | start;

    // full flag tracks the busy levels one edge ahead
    // so the requester sees it before the next strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_full <= 1'b0;
        end else begin
            req_full <= &busy_next;
        end
    end

endmodule

// ==== rtl/load_pkg.sv ====
package load_pkg;

    // data and address width of the core
    localparam int xlen = 64;

    // destination register tag, x0 to x31
    localparam int tag_width = 5;

    // access size codes, as in funct3[1:0] of the load opcodes
    localparam logic [1:0] size_byte  = 2'd0;
    localparam logic [1:0] size_half  = 2'd1;
    localparam logic [1:0] size_word  = 2'd2;
    localparam logic [1:0] size_dword = 2'd3;

    // number of low address bits that pick a byte inside the doubleword
    localparam int lane_bits = 3;

    // one read beat seen either whole or split into naturally aligned lanes
    // lane index comes straight from the low address bits:
    //   byte  -> addr[2:0]
    //   half  -> addr[2:1]
    //   word  -> addr[2]
    typedef union packed {
        // whole doubleword
        logic [xlen-1:0]  dword;
        // eight byte lanes, lane 0 at bits 7:0
        logic [7:0][7:0]  b;
        // four halfword lanes
        logic [3:0][15:0] h;
        // two word lanes
        logic [1:0][31:0] w;
    } dword_lanes_u;

endpackage
